/* logic/soc_pkg.sv */
package soc_pkg;

   // Bus geometry
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // Top address bits that pick a slave region
   localparam int SEL_W = 2;

   // Slave regions in address order
   typedef enum logic [SEL_W-1:0] {
      REGION_BOOT  = 2'd0,
      REGION_UART  = 2'd1,
      REGION_RESET = 2'd2,
      REGION_RAM   = 2'd3
   } region_t;

   // UART register offsets, word address bits 4 to 2
   typedef enum logic [2:0] {
      UART_TXDATA  = 3'd0,
      UART_TXBUSY  = 3'd1,
      UART_RXDATA  = 3'd2,
      UART_RXVALID = 3'd3,
      UART_DIV     = 3'd4
   } uart_reg_t;

   // Shared by the transmit and receive FSMs
   typedef enum logic [1:0] {
      UART_IDLE  = 2'd0,
      UART_START = 2'd1,
      UART_DATA  = 2'd2,
      UART_STOP  = 2'd3
   } uart_state_t;

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if import soc_pkg::*; ();

   // Request side, held steady until ready is seen
   logic              valid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W/8-1:0] wstrb;

   // Response side, one-cycle ready with rdata alongside
   logic              ready;
   logic [DATA_W-1:0] rdata;

   modport master (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  ready,
      input  rdata
   );

   modport slave (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output ready,
      output rdata
   );

endinterface

/* logic/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder import soc_pkg::*; (
   mem_bus_if.slave  cpu,
   mem_bus_if.master boot_bus,
   mem_bus_if.master uart_bus,
   mem_bus_if.master reset_bus,
   mem_bus_if.master ram_bus,
   input  logic      boot
);

   region_t addr_region;
   region_t region;

   assign addr_region = region_t'(cpu.addr[ADDR_W-1 -: SEL_W]);

   // After the soft reset, region 0 is served by the main memory
   assign region = (!boot && addr_region == REGION_BOOT) ? REGION_RAM : addr_region;

   // Request fields go to every slave
   assign boot_bus.addr   = cpu.addr;
   assign boot_bus.wdata  = cpu.wdata;
   assign boot_bus.wstrb  = cpu.wstrb;
   assign uart_bus.addr   = cpu.addr;
   assign uart_bus.wdata  = cpu.wdata;
   assign uart_bus.wstrb  = cpu.wstrb;
   assign reset_bus.addr  = cpu.addr;
   assign reset_bus.wdata = cpu.wdata;
   assign reset_bus.wstrb = cpu.wstrb;
   assign ram_bus.addr    = cpu.addr;
   assign ram_bus.wdata   = cpu.wdata;
   assign ram_bus.wstrb   = cpu.wstrb;

   // Only the selected slave sees valid
   assign boot_bus.valid  = cpu.valid && (region == REGION_BOOT);
   assign uart_bus.valid  = cpu.valid && (region == REGION_UART);
   assign reset_bus.valid = cpu.valid && (region == REGION_RESET);
   assign ram_bus.valid   = cpu.valid && (region == REGION_RAM);

   // Response path back to the master
   always_comb begin
      case (region)
         REGION_BOOT: begin
            cpu.ready = boot_bus.ready;
            cpu.rdata = boot_bus.rdata;
         end
         REGION_UART: begin
            cpu.ready = uart_bus.ready;
            cpu.rdata = uart_bus.rdata;
         end
         REGION_RESET: begin
            cpu.ready = reset_bus.ready;
            cpu.rdata = reset_bus.rdata;
         end
         default: begin
            cpu.ready = ram_bus.ready;
            cpu.rdata = ram_bus.rdata;
         end
      endcase
   end

endmodule

/* logic/sram.sv */
`timescale 1ns/1ps

module sram import soc_pkg::*; #(
   parameter int ADDR_W_WORDS = 8
) (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus
);

   localparam int DEPTH = 1 << ADDR_W_WORDS;

   logic [DATA_W-1:0]       mem [DEPTH];
   logic [ADDR_W_WORDS-1:0] word_addr;
   logic [DATA_W-1:0]       rdata_q;
   logic                    ready_q;
   logic                    access;

   // Upper address bits are dropped, so the array repeats in its region
   assign word_addr = bus.addr[ADDR_W_WORDS+1:2];

   // No new access in the ready cycle of the previous one
   assign access = bus.valid && !ready_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= access;
      end
   end

   // Read returns the word as it was before a write in the same access
   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= mem[word_addr];
         for (int lane = 0; lane < DATA_W/8; lane++) begin
            if (bus.wstrb[lane]) begin
               mem[word_addr][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
            end
         end
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;

endmodule

/* logic/uart_core.sv */
`timescale 1ns/1ps

module uart_core import soc_pkg::*; #(
   parameter int UART_DIV_RESET = 8
) (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus,
   output logic     txd,
   output logic     rts,
   input  logic     rxd,
   input  logic     cts
);

   localparam int DIV_W = 16;

   uart_reg_t   reg_sel;
   logic        ready_q;
   logic        access;
   logic        wr_en;
   logic        rd_en;
   logic [DATA_W-1:0] read_word;
   logic [DATA_W-1:0] rdata_q;
   logic [DIV_W-1:0]  div_q;

   uart_state_t      tx_state;
   logic [DIV_W-1:0] tx_cnt;
   logic [2:0]       tx_bit;
   logic [7:0]       tx_shift;
   logic             tx_pending;
   logic             tx_busy;
   logic             tx_load;
   logic             tx_last;
   logic             txd_q;

   uart_state_t      rx_state;
   logic [DIV_W-1:0] rx_cnt;
   logic [DIV_W-1:0] rx_limit;
   logic [2:0]       rx_bit;
   logic [7:0]       rx_shift;
   logic [7:0]       rx_data;
   logic             rx_valid;
   logic             rx_last;
   logic [1:0]       rx_sync;

   assign reg_sel = uart_reg_t'(bus.addr[4:2]);
   assign access  = bus.valid && !ready_q;
   assign wr_en   = access && (bus.wstrb != '0);
   assign rd_en   = access && (bus.wstrb == '0);

   // Busy covers a byte held back by CTS as well as one on the line
   assign tx_busy = tx_pending || (tx_state != UART_IDLE);
   assign tx_load = wr_en && (reg_sel == UART_TXDATA) && !tx_busy;
   assign tx_last = (tx_cnt + 16'd1 >= div_q);

   // Start bit is checked at half a bit, data and stop a full bit later
   assign rx_limit = (rx_state == UART_START) ? (div_q >> 1) : div_q;
   assign rx_last  = (rx_cnt + 16'd1 >= rx_limit);

   always_comb begin
      case (reg_sel)
         UART_TXBUSY:  read_word = DATA_W'(tx_busy);
         UART_RXDATA:  read_word = DATA_W'(rx_data);
         UART_RXVALID: read_word = DATA_W'(rx_valid);
         UART_DIV:     read_word = DATA_W'(div_q);
         default:      read_word = '0;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         div_q   <= DIV_W'(UART_DIV_RESET);
      end else begin
         ready_q <= access;
         if (wr_en && reg_sel == UART_DIV) begin
            div_q <= bus.wdata[DIV_W-1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdata_q <= read_word;
      end
   end

   // Transmitter, 8N1 with LSB first
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_state   <= UART_IDLE;
         tx_cnt     <= '0;
         tx_bit     <= '0;
         tx_shift   <= '0;
         tx_pending <= 1'b0;
         txd_q      <= 1'b1;
      end else begin
         if (tx_load) begin
            tx_shift   <= bus.wdata[7:0];
            tx_pending <= 1'b1;
         end
         case (tx_state)
            UART_IDLE: begin
               tx_cnt <= '0;
               // Hold the byte until the far end allows it
               if (tx_pending && cts) begin
                  tx_pending <= 1'b0;
                  txd_q      <= 1'b0;
                  tx_state   <= UART_START;
               end
            end
            UART_START: begin
               tx_cnt <= tx_last ? '0 : tx_cnt + 16'd1;
               if (tx_last) begin
                  tx_bit   <= '0;
                  txd_q    <= tx_shift[0];
                  tx_state <= UART_DATA;
               end
            end
            UART_DATA: begin
               tx_cnt <= tx_last ? '0 : tx_cnt + 16'd1;
               if (tx_last) begin
                  if (tx_bit == 3'd7) begin
                     txd_q    <= 1'b1;
                     tx_state <= UART_STOP;
                  end else begin
                     tx_shift <= {1'b0, tx_shift[7:1]};
                     txd_q    <= tx_shift[1];
                     tx_bit   <= tx_bit + 3'd1;
                  end
               end
            end
            UART_STOP: begin
               tx_cnt <= tx_last ? '0 : tx_cnt + 16'd1;
               if (tx_last) begin
                  tx_state <= UART_IDLE;
               end
            end
         endcase
      end
   end

   // Receiver, rxd synchronised first
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rx_sync  <= 2'b11;
         rx_state <= UART_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_shift <= '0;
         rx_data  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
         if (rd_en && reg_sel == UART_RXDATA) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            UART_IDLE: begin
               rx_cnt <= '0;
               if (!rx_sync[1]) begin
                  rx_state <= UART_START;
               end
            end
            UART_START: begin
               rx_cnt <= rx_last ? '0 : rx_cnt + 16'd1;
               if (rx_last) begin
                  // A glitch shorter than half a bit is ignored
                  rx_bit   <= '0;
                  rx_state <= rx_sync[1] ? UART_IDLE : UART_DATA;
               end
            end
            UART_DATA: begin
               rx_cnt <= rx_last ? '0 : rx_cnt + 16'd1;
               if (rx_last) begin
                  rx_shift <= {rx_sync[1], rx_shift[7:1]};
                  rx_bit   <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= UART_STOP;
                  end
               end
            end
            UART_STOP: begin
               rx_cnt <= rx_last ? '0 : rx_cnt + 16'd1;
               if (rx_last) begin
                  // New byte replaces an unread one
                  if (rx_sync[1]) begin
                     rx_data  <= rx_shift;
                     rx_valid <= 1'b1;
                  end
                  rx_state <= UART_IDLE;
               end
            end
         endcase
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;
   assign txd       = txd_q;
   assign rts       = !rx_valid;

endmodule

/* logic/reset_ctrl.sv */
`timescale 1ns/1ps

module reset_ctrl (
   input  logic     clk,
   input  logic     reset,
   mem_bus_if.slave bus,
   output logic     boot,
   output logic     core_reset
);

   logic access;
   logic ready_q;
   logic pulse_q;
   logic boot_q;

   assign access = bus.valid && !ready_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         pulse_q <= 1'b0;
         boot_q  <= 1'b1;
      end else begin
         ready_q <= access;
         // Any write restarts the core on the main memory map
         pulse_q <= access && (bus.wstrb != '0);
         if (access && bus.wstrb != '0) begin
            boot_q <= 1'b0;
         end
      end
   end

   assign bus.ready  = ready_q;
   assign bus.rdata  = '0;
   assign boot       = boot_q;
   assign core_reset = pulse_q;

endmodule

/* logic/soc_system.sv */
`timescale 1ns/1ps

module soc_system import soc_pkg::*; #(
   parameter int BOOT_ADDR_W    = 8,
   parameter int RAM_ADDR_W     = 10,
   parameter int UART_DIV_RESET = 8
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                mem_valid,
   input  logic [ADDR_W-1:0]   mem_addr,
   input  logic [DATA_W-1:0]   mem_wdata,
   input  logic [DATA_W/8-1:0] mem_wstrb,
   output logic                mem_ready,
   output logic [DATA_W-1:0]   mem_rdata,
   output logic                core_reset,
   output logic                uart_txd,
   output logic                uart_rts,
   input  logic                uart_rxd,
   input  logic                uart_cts
);

   logic boot;

   mem_bus_if cpu_bus ();
   mem_bus_if boot_bus ();
   mem_bus_if uart_bus ();
   mem_bus_if reset_bus ();
   mem_bus_if ram_bus ();

   // Master side comes in on plain ports
   assign cpu_bus.valid = mem_valid;
   assign cpu_bus.addr  = mem_addr;
   assign cpu_bus.wdata = mem_wdata;
   assign cpu_bus.wstrb = mem_wstrb;
   assign mem_ready     = cpu_bus.ready;
   assign mem_rdata     = cpu_bus.rdata;

   bus_decoder decoder0 (
      .cpu       (cpu_bus.slave),
      .boot_bus  (boot_bus.master),
      .uart_bus  (uart_bus.master),
      .reset_bus (reset_bus.master),
      .ram_bus   (ram_bus.master),
      .boot      (boot)
   );

   sram #(
      .ADDR_W_WORDS (BOOT_ADDR_W)
   ) boot_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (boot_bus.slave)
   );

   sram #(
      .ADDR_W_WORDS (RAM_ADDR_W)
   ) main_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus.slave)
   );

   uart_core #(
      .UART_DIV_RESET (UART_DIV_RESET)
   ) uart0 (
      .clk   (clk),
      .reset (reset),
      .bus   (uart_bus.slave),
      .txd   (uart_txd),
      .rts   (uart_rts),
      .rxd   (uart_rxd),
      .cts   (uart_cts)
   );

   reset_ctrl reset0 (
      .clk        (clk),
      .reset      (reset),
      .bus        (reset_bus.slave),
      .boot       (boot),
      .core_reset (core_reset)
   );

endmodule

/* test/soc_system_assertions.sv */
`timescale 1ns/1ps

module soc_system_assertions (
   input logic clk,
   input logic reset,
   input logic valid,
   input logic ready,
   input logic pulse
);

   // A slave only answers a request that is still held
   ready_needs_valid: assert property (
      @(posedge clk) disable iff (reset) ready |-> valid
   ) else $error("ready high without valid");

   // One ready pulse per request
   ready_one_cycle: assert property (
      @(posedge clk) disable iff (reset) ready |=> !ready
   ) else $error("ready held for more than one cycle");

   core_reset_one_cycle: assert property (
      @(posedge clk) disable iff (reset) pulse |=> !pulse
   ) else $error("core_reset held for more than one cycle");

endmodule

/* test/soc_system_tb.sv */
`timescale 1ns/1ps

module soc_system_tb;

   typedef enum {OP_READ, OP_WRITE, OP_SEND, OP_SEND_HELD} op_t;

   localparam int NUM_ROWS        = 23;
   localparam int BIT_CLKS        = 10;
   localparam int READY_LIMIT     = 20;
   localparam int POLL_LIMIT      = 6 * BIT_CLKS;
   localparam int WATCHDOG_CYCLES = 16 + NUM_ROWS * (40 + 12 * BIT_CLKS);

   // UART registers at word offsets in region 1
   localparam logic [15:0] TXDATA_ADDR  = 16'h4000;
   localparam logic [15:0] TXBUSY_ADDR  = 16'h4004;
   localparam logic [15:0] RXDATA_ADDR  = 16'h4008;
   localparam logic [15:0] RXVALID_ADDR = 16'h400c;
   localparam logic [15:0] DIV_ADDR     = 16'h4010;

   logic        clk;
   logic        reset;
   logic        mem_valid;
   logic [15:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [3:0]  mem_wstrb;
   logic        mem_ready;
   logic [31:0] mem_rdata;
   logic        core_reset;
   logic        uart_txd;
   logic        uart_rts;
   logic        uart_cts;

   op_t         row_op     [NUM_ROWS];
   logic [15:0] row_addr   [NUM_ROWS];
   logic [31:0] row_wdata  [NUM_ROWS];
   logic [3:0]  row_strb   [NUM_ROWS];
   logic [31:0] row_expect [NUM_ROWS];
   string       row_name   [NUM_ROWS];

   logic [31:0] seed = 32'hd37;
   int          errors = 0;
   int          reset_pulses = 0;

   // Serial output looped straight back into the receiver
   soc_system #(
      .BOOT_ADDR_W    (8),
      .RAM_ADDR_W     (10),
      .UART_DIV_RESET (8)
   ) dut0 (
      .clk        (clk),
      .reset      (reset),
      .mem_valid  (mem_valid),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .mem_ready  (mem_ready),
      .mem_rdata  (mem_rdata),
      .core_reset (core_reset),
      .uart_txd   (uart_txd),
      .uart_rts   (uart_rts),
      .uart_rxd   (uart_txd),
      .uart_cts   (uart_cts)
   );

   // Decoder master side is the same as the top-level bus ports
   bind soc_system soc_system_assertions cpu_side_checks (
      .clk   (clk),
      .reset (reset),
      .valid (mem_valid),
      .ready (mem_ready),
      .pulse (core_reset)
   );

   bind reset_ctrl soc_system_assertions reset_side_checks (
      .clk   (clk),
      .reset (reset),
      .valid (bus.valid),
      .ready (bus.ready),
      .pulse (core_reset)
   );

   always #10 clk = ~clk;

   // Counts cycles with core_reset high
   always @(negedge clk) begin
      if (core_reset === 1'b1) begin
         reset_pulses++;
      end
   end

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            result[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return result;
   endfunction

   task automatic set_row(input int idx, input op_t op, input logic [15:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [31:0] expect_word, input string name);
      row_op[idx]     = op;
      row_addr[idx]   = addr;
      row_wdata[idx]  = wdata;
      row_strb[idx]   = strb;
      row_expect[idx] = expect_word;
      row_name[idx]   = name;
   endtask

   task automatic build_table();
      logic [31:0] w [9];
      for (int k = 0; k < 9; k++) begin
         seed = next_random(seed);
         w[k] = seed;
      end
      set_row(0, OP_WRITE, 16'h0000, w[0], 4'hf, 32'd0, "boot write 0");
      set_row(1, OP_WRITE, 16'h0004, w[1], 4'hf, 32'd0, "boot write 1");
      set_row(2, OP_WRITE, 16'hc000, w[2], 4'hf, 32'd0, "ram write 0");
      set_row(3, OP_WRITE, 16'hc004, w[3], 4'hf, 32'd0, "ram write 1");
      set_row(4, OP_READ, 16'h0000, 32'd0, 4'h0, w[0], "boot read 0");
      set_row(5, OP_READ, 16'h0004, 32'd0, 4'h0, w[1], "boot read 1");
      set_row(6, OP_READ, 16'hc000, 32'd0, 4'h0, w[2], "ram read 0");
      set_row(7, OP_READ, 16'hc004, 32'd0, 4'h0, w[3], "ram read 1");
      set_row(8, OP_WRITE, 16'hc004, w[4], 4'b0101, 32'd0, "ram lanes 0 and 2");
      set_row(9, OP_READ, 16'hc004, 32'd0, 4'h0, merge_lanes(w[3], w[4], 4'b0101),
              "ram merged read");
      set_row(10, OP_WRITE, 16'h0004, w[5], 4'b1000, 32'd0, "boot lane 3");
      set_row(11, OP_READ, 16'h0004, 32'd0, 4'h0, merge_lanes(w[1], w[5], 4'b1000),
              "boot merged read");
      set_row(12, OP_WRITE, 16'h8000, 32'd1, 4'hf, 32'd0, "soft reset");
      set_row(13, OP_READ, 16'h8000, 32'd0, 4'h0, 32'd0, "reset reg read");
      set_row(14, OP_READ, 16'h0000, 32'd0, 4'h0, w[2], "remapped read 0");
      set_row(15, OP_READ, 16'h0004, 32'd0, 4'h0, merge_lanes(w[3], w[4], 4'b0101),
              "remapped read 1");
      set_row(16, OP_WRITE, DIV_ADDR, BIT_CLKS, 4'hf, 32'd0, "uart divisor write");
      set_row(17, OP_READ, DIV_ADDR, 32'd0, 4'h0, BIT_CLKS, "uart divisor read");
      set_row(18, OP_SEND, TXDATA_ADDR, w[6], 4'hf, {24'd0, w[6][7:0]}, "uart byte 0");
      set_row(19, OP_SEND, TXDATA_ADDR, w[7], 4'hf, {24'd0, w[7][7:0]}, "uart byte 1");
      set_row(20, OP_SEND_HELD, TXDATA_ADDR, w[8], 4'hf, {24'd0, w[8][7:0]},
              "uart held by cts");
      set_row(21, OP_READ, TXBUSY_ADDR, 32'd0, 4'h0, 32'd0, "uart tx idle");
      set_row(22, OP_READ, RXVALID_ADDR, 32'd0, 4'h0, 32'd0, "uart rx empty");
   endtask

   // One request, held until ready is seen, then dropped for a cycle
   task automatic bus_access(input logic [15:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, output logic [31:0] rdata);
      int waited;
      waited = 0;
      rdata  = '0;
      @(negedge clk);
      mem_valid = 1'b1;
      mem_addr  = addr;
      mem_wdata = wdata;
      mem_wstrb = strb;
      @(negedge clk);
      while (mem_ready !== 1'b1 && waited < READY_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      if (mem_ready === 1'b1) begin
         rdata = mem_rdata;
      end else begin
         $display("no ready from the DUT for address %h at %0t", addr, $time);
         errors++;
      end
      @(negedge clk);
      mem_valid = 1'b0;
      mem_wstrb = '0;
   endtask

   task automatic send_byte(input logic [7:0] data, input logic [7:0] expect_byte,
                            input logic held);
      logic [31:0] word;
      int          polls;
      polls = 0;
      word  = 32'd1;
      while (word != 32'd0 && polls < POLL_LIMIT) begin
         bus_access(TXBUSY_ADDR, '0, 4'h0, word);
         polls++;
      end
      if (held) begin
         @(negedge clk);
         uart_cts = 1'b0;
      end
      bus_access(TXDATA_ADDR, {24'd0, data}, 4'hf, word);
      if (held) begin
         repeat (2 * BIT_CLKS) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
               $display("uart_txd left idle while uart_cts was low at %0t", $time);
               errors++;
            end
         end
         bus_access(TXBUSY_ADDR, '0, 4'h0, word);
         if (word !== 32'd1) begin
            $display("mismatch at %0t: TXBUSY read %h, expected 1", $time, word);
            errors++;
         end
         @(negedge clk);
         uart_cts = 1'b1;
      end
      // Wait for the looped byte
      polls = 0;
      word  = 32'd0;
      while (word != 32'd1 && polls < POLL_LIMIT) begin
         bus_access(RXVALID_ADDR, '0, 4'h0, word);
         polls++;
      end
      if (word !== 32'd1) begin
         $display("no byte came back on the loopback by %0t", $time);
         errors++;
      end
      if (uart_rts !== 1'b0) begin
         $display("uart_rts stayed high with an unread byte at %0t", $time);
         errors++;
      end
      bus_access(RXDATA_ADDR, '0, 4'h0, word);
      if (word !== {24'd0, expect_byte}) begin
         $display("mismatch at %0t: RXDATA read %h, expected %h", $time, word, expect_byte);
         errors++;
      end
      if (uart_rts !== 1'b1) begin
         $display("uart_rts still low after RXDATA was read at %0t", $time);
         errors++;
      end
      bus_access(RXVALID_ADDR, '0, 4'h0, word);
      if (word !== 32'd0) begin
         $display("mismatch at %0t: RXVALID read %h after RXDATA, expected 0", $time, word);
         errors++;
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * 20);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      logic [31:0] data;
      int          errors_before;
      int          pulses_before;
      int          pulses_expected;
      int          rows_passed;
      int          rows_failed;
      clk         = 1'b0;
      reset       = 1'b1;
      mem_valid   = 1'b0;
      mem_addr    = '0;
      mem_wdata   = '0;
      mem_wstrb   = '0;
      uart_cts    = 1'b1;
      rows_passed = 0;
      rows_failed = 0;
      build_table();
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (mem_ready !== 1'b0 || core_reset !== 1'b0 || uart_txd !== 1'b1 ||
          uart_rts !== 1'b1) begin
         $display("outputs are not at their reset values after reset");
         errors++;
      end
      for (int i = 0; i < NUM_ROWS; i++) begin
         errors_before = errors;
         pulses_before = reset_pulses;
         case (row_op[i])
            OP_READ: begin
               bus_access(row_addr[i], '0, 4'h0, data);
               if (data !== row_expect[i]) begin
                  $display("mismatch at %0t: %s read %h, expected %h", $time,
                           row_name[i], data, row_expect[i]);
                  errors++;
               end
            end
            OP_WRITE: begin
               bus_access(row_addr[i], row_wdata[i], row_strb[i], data);
            end
            OP_SEND: begin
               send_byte(row_wdata[i][7:0], row_expect[i][7:0], 1'b0);
            end
            default: begin
               send_byte(row_wdata[i][7:0], row_expect[i][7:0], 1'b1);
            end
         endcase
         // Only a write to the soft-reset register pulses core_reset, for one cycle
         pulses_expected = (row_op[i] == OP_WRITE && row_addr[i][15:14] == 2'd2) ? 1 : 0;
         if (reset_pulses != pulses_before + pulses_expected) begin
            $display("mismatch at %0t: core_reset high for %0d cycles, expected %0d",
                     $time, reset_pulses - pulses_before, pulses_expected);
            errors++;
         end
         if (errors == errors_before) begin
            rows_passed++;
            $display("row %0d %s: ok", i, row_name[i]);
         end else begin
            rows_failed++;
            $display("row %0d %s: failed", i, row_name[i]);
         end
      end
      $display("%0d rows run, %0d passed, %0d failed, %0d errors", NUM_ROWS, rows_passed,
               rows_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* soc_system.f */
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/bus_decoder.sv
logic/sram.sv
logic/uart_core.sv
logic/reset_ctrl.sv
logic/soc_system.sv
test/soc_system_assertions.sv
test/soc_system_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_system_tb
FILELIST  ?= soc_system.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
